// File: logic/isa_pkg.sv
/*
	Instruction word formats and opcode constants of the 16-bit minicomputer ISA.
	Bit numbering follows the reference manuals: IR bit 0 is the MSB, so the
	opcode (IR 0:5) sits in the top six bits of the packed word.
	Opcode values are given in octal, as in the machine documentation.
*/

package isa_pkg;

	// Two-register / normal argument layout
	typedef struct packed {
		logic [5:0] op;		// IR 0:5
		logic d;			// IR 6, D modifier
		logic [2:0] a;		// IR 7:9, register A
		logic [2:0] b;		// IR 10:12, B-modification register
		logic [2:0] c;		// IR 13:15, C=0 means argument in next word
	} norm_fmt_t;

	// KA1 short argument layout
	typedef struct packed {
		logic [5:0] op;		// IR 0:5
		logic d;			// Sign of short argument
		logic [2:0] a;		// IR 7:9
		logic [5:0] t;		// IR 10:15, argument magnitude
	} shrt_fmt_t;

	// Same IR bits, read either way
	typedef union packed {
		norm_fmt_t norm;
		shrt_fmt_t shrt;
	} insn_word_t;

	// Single-opcode groups
	localparam logic [5:0] OP_JS  = 6'o70;	// Short conditional jumps
	localparam logic [5:0] OP_KA2 = 6'o71;
	localparam logic [5:0] OP_C   = 6'o72;
	localparam logic [5:0] OP_S   = 6'o73;	// System group, HLT..LIP
	localparam logic [5:0] OP_J   = 6'o74;	// Conditional jumps
	localparam logic [5:0] OP_L   = 6'o75;
	localparam logic [5:0] OP_G   = 6'o76;
	localparam logic [5:0] OP_BN  = 6'o77;

	// Opcode ranges
	localparam logic [5:0] OP_KA1_LO  = 6'o60;
	localparam logic [5:0] OP_KA1_HI  = 6'o67;
	localparam logic [5:0] OP_NORM_LO = 6'o20;
	localparam logic [5:0] OP_NORM_HI = 6'o57;

	// IN/OU live below 020, top bits 00
	localparam logic [5:0] OP_IN = 6'o06;
	localparam logic [5:0] OP_OU = 6'o07;

	// Highest A field that names a real S group instruction
	localparam logic [2:0] S_A_MAX = 3'd4;

endpackage

// File: logic/ctl_pkg.sv
/*
	Decode stage control types: instruction class, R0 flags, the decode
	record passed downstream and the configuration register map.
	The record carries the raw word as plain bits.
*/

package ctl_pkg;

	typedef enum logic [2:0] {
		CL_NORM,		// 020..057, normal argument
		CL_SHORT,		// KA1, short argument
		CL_JUMP_S,
		CL_JUMP,
		CL_SYS,
		CL_BN,
		CL_IO,
		CL_OTHER
	} insn_class_e;

	// R0 bits 0:8, z is the MSB
	typedef struct packed {
		logic z;
		logic m;
		logic v;
		logic c;
		logic l;
		logic e;
		logic g;
		logic y;
		logic x;
	} r0_flags_t;

	typedef struct packed {
		logic [15:0] word;			// IR as decoded
		insn_class_e cls;
		logic [2:0] reg_a;
		logic [2:0] reg_b;
		logic signed [6:0] short_arg;	// KA1 argument, D gives sign
		logic need_arg;				// Argument word follows
		logic illegal;
		logic ineffective;
	} decode_rec_t;

	typedef struct packed {
		logic inou_user_illegal;	// wdata bit 1
		logic drop_ineffective;		// wdata bit 0
	} cfg_t;

	localparam logic CFG_ADDR_CTRL   = 1'b0;
	localparam logic CFG_ADDR_ILLCNT = 1'b1;
	localparam int CFG_DATA_W = 8;
	localparam int ILLCNT_W   = 8;

endpackage

// File: logic/ir_stage.sv
/*
	One-entry instruction register on a valid/ready input.
	Refills on the same edge it empties.
	invalidate holds the IR for that cycle and zeroes IR bits 0:1, so the
	word decodes as illegal on the following cycle.
*/
`timescale 1ns/1ps

module ir_stage import isa_pkg::*; (
	input logic strob1,
	input logic rst_n,
	input logic in_valid,
	input insn_word_t in_word,
	input logic invalidate,
	input logic ir_take,
	output logic in_ready,
	output insn_word_t ir,
	output logic ir_valid
);

	logic ir_full;		// IR holds a word
	logic load;

	// Word stays put while invalidate rewrites it
	assign ir_valid = ir_full & ~invalidate;
	assign in_ready = ~ir_full | ir_take;
	assign load = in_valid & in_ready;

	always_ff @(posedge strob1) begin
		if (!rst_n) begin
			ir_full <= 1'b0;
		end else if (in_ready) begin
			ir_full <= in_valid;	// Empty, or emptying this edge
		end
	end

	// IR payload
	always_ff @(posedge strob1) begin
		if (load) begin
			ir <= in_word;
		end else if (ir_full && invalidate) begin
			ir.norm.op[5:4] <= 2'b00;	// Kill opcode group
		end
	end

endmodule

// File: logic/opcode_decoder.sv
/*
	Combinational field and class decode of the IR.
	illegal and ineffective are left at zero; legality_check fills them.
	short_arg is only non-zero for the KA1 group.
*/
`timescale 1ns/1ps

module opcode_decoder import isa_pkg::*, ctl_pkg::*; (
	input insn_word_t ir,
	output decode_rec_t rec
);

	logic [5:0] op;
	insn_class_e cls;
	logic signed [6:0] t_ext;

	assign op = ir.norm.op;
	assign t_ext = {1'b0, ir.shrt.t};	// Magnitude, always positive

	always_comb begin
		if (op >= OP_NORM_LO && op <= OP_NORM_HI) begin
			cls = CL_NORM;
		end else if (op >= OP_KA1_LO && op <= OP_KA1_HI) begin
			cls = CL_SHORT;
		end else begin
			case (op)
				OP_JS: cls = CL_JUMP_S;
				OP_J: cls = CL_JUMP;
				OP_S: cls = CL_SYS;
				OP_BN: cls = CL_BN;
				OP_IN, OP_OU: cls = CL_IO;
				default: cls = CL_OTHER;	// KA2, C, L, G and the 00 group
			endcase
		end
	end

	always_comb begin
		rec = '0;
		rec.word = ir;
		rec.cls = cls;
		rec.reg_a = ir.norm.a;
		rec.reg_b = ir.norm.b;
		if (cls == CL_SHORT) begin
			rec.short_arg = ir.shrt.d ? -t_ext : t_ext;	// D set, negative
		end
		// Argument word follows when C is zero
		rec.need_arg = (cls == CL_NORM || cls == CL_IO) && (ir.norm.c == 3'd0);
	end

endmodule

// File: logic/legality_check.sv
/*
	Illegal/ineffective judgement and the registered output stage.
	Record is captured when the IR is valid and the output register is
	empty or being read. With drop_ineffective set, ineffective words are
	consumed without a record. ill_event counts only records that are kept.
*/
`timescale 1ns/1ps

module legality_check import isa_pkg::*, ctl_pkg::*; (
	input logic strob1,
	input logic rst_n,
	input decode_rec_t rec_in,
	input logic ir_valid,
	input r0_flags_t r0,
	input logic q,
	input logic p,
	input cfg_t cfg,
	input logic out_ready,
	output logic ir_take,
	output logic ill_event,
	output logic out_valid,
	output decode_rec_t out_rec
);

	logic [1:0] op_hi;		// IR bits 0:1
	logic illegal;
	logic jump_nef;		// Condition flag clear
	logic ineff;
	logic drop;
	logic out_free;

	assign op_hi = rec_in.word[15:14];

	assign illegal = (op_hi == 2'b00 && rec_in.cls != CL_IO)
		|| (rec_in.cls == CL_SYS && (rec_in.reg_a > S_A_MAX || q))	// Bad A, or user mode
		|| (rec_in.cls == CL_IO && q && cfg.inou_user_illegal);

	always_comb begin
		jump_nef = 1'b0;
		if (rec_in.cls == CL_JUMP_S) begin
			case (rec_in.reg_a)
				3'd4: jump_nef = ~r0.v;
				3'd5: jump_nef = ~r0.x;
				3'd6: jump_nef = ~r0.y;
				3'd7: jump_nef = ~r0.c;
				default: jump_nef = 1'b0;	// Unconditional forms
			endcase
		end else if (rec_in.cls == CL_JUMP) begin
			case (rec_in.reg_a)
				3'd1: jump_nef = ~r0.l;
				3'd2: jump_nef = ~r0.e;
				3'd3: jump_nef = ~r0.g;
				3'd4: jump_nef = ~r0.z;
				3'd5: jump_nef = ~r0.m;
				default: jump_nef = 1'b0;
			endcase
		end
	end

	assign ineff = illegal | p | jump_nef;	// P set skips anything
	assign drop = ineff & cfg.drop_ineffective;
	assign out_free = ~out_valid | out_ready;
	assign ir_take = ir_valid & out_free;
	assign ill_event = ir_take & illegal & ~drop;

	always_ff @(posedge strob1) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (out_free) begin
			out_valid <= ir_valid & ~drop;
		end
	end

	always_ff @(posedge strob1) begin
		if (ir_take && !drop) begin
			out_rec <= rec_in;
			out_rec.illegal <= illegal;
			out_rec.ineffective <= ineff;
		end
	end

endmodule

// File: logic/decode_cfg.sv
/*
	Configuration register and saturating illegal-instruction counter.
	Writes land at the next edge; reads are combinational.
	Any write to the counter address clears it.
*/
`timescale 1ns/1ps

module decode_cfg import ctl_pkg::*; (
	input logic strob1,
	input logic rst_n,
	input logic cfg_wr,
	input logic cfg_addr,
	input logic [CFG_DATA_W-1:0] cfg_wdata,
	input logic ill_event,
	output logic [CFG_DATA_W-1:0] cfg_rdata,
	output cfg_t cfg
);

	logic [ILLCNT_W-1:0] ill_cnt;

	always_ff @(posedge strob1) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (cfg_wr && cfg_addr == CFG_ADDR_CTRL) begin
			cfg <= cfg_t'(cfg_wdata[1:0]);	// Bit 1 IN/OU, bit 0 drop
		end
	end

	always_ff @(posedge strob1) begin
		if (!rst_n) begin
			ill_cnt <= '0;
		end else if (cfg_wr && cfg_addr == CFG_ADDR_ILLCNT) begin
			ill_cnt <= '0;	// Clear on write
		end else if (ill_event && ill_cnt != '1) begin
			ill_cnt <= ill_cnt + 1'b1;	// Sticks at max
		end
	end

	assign cfg_rdata = (cfg_addr == CFG_ADDR_CTRL) ? CFG_DATA_W'(cfg) : CFG_DATA_W'(ill_cnt);

endmodule

// File: logic/decode_unit.sv
/*
	Instruction decode stage top level.
	Two cycles from input handshake to output record with no stalls.
	Side inputs r0, q and p are sampled while the word sits in the IR.
*/
`timescale 1ns/1ps

module decode_unit import isa_pkg::*, ctl_pkg::*; (
	input logic strob1,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input insn_word_t in_word,
	output logic out_valid,
	input logic out_ready,
	output decode_rec_t out_rec,
	input logic cfg_wr,
	input logic cfg_addr,
	input logic [CFG_DATA_W-1:0] cfg_wdata,
	output logic [CFG_DATA_W-1:0] cfg_rdata,
	input r0_flags_t r0,
	input logic q,
	input logic p,
	input logic invalidate
);

	insn_word_t ir;
	logic ir_valid;
	logic ir_take;
	logic ill_event;
	decode_rec_t dec_rec;	// Partial, legality bits zero
	cfg_t cfg;

	ir_stage u_ir_stage (
		.strob1(strob1), .rst_n(rst_n),
		.in_valid(in_valid), .in_word(in_word), .invalidate(invalidate),
		.ir_take(ir_take), .in_ready(in_ready), .ir(ir), .ir_valid(ir_valid)
	);

	opcode_decoder u_opcode_decoder (.ir(ir), .rec(dec_rec));

	legality_check u_legality_check (
		.strob1(strob1), .rst_n(rst_n),
		.rec_in(dec_rec), .ir_valid(ir_valid), .r0(r0), .q(q), .p(p), .cfg(cfg),
		.out_ready(out_ready), .ir_take(ir_take), .ill_event(ill_event),
		.out_valid(out_valid), .out_rec(out_rec)
	);

	decode_cfg u_decode_cfg (
		.strob1(strob1), .rst_n(rst_n),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.ill_event(ill_event), .cfg_rdata(cfg_rdata), .cfg(cfg)
	);

endmodule

// File: verification/tb_clock.sv
/*
	Testbench clock and reset source.
	8 ns period, rst_n low for the first two rising edges.
*/
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;	// Released just after the second edge
	end

endmodule

// File: verification/decode_tb.sv
/*
	Directed testbench for decode_unit.
	Inputs change 1 ns after the rising edge, outputs are sampled at the
	falling edge. r0, q and p are held constant while a word is in flight.
	Expected records come from a local model of the decode rules.
*/
`timescale 1ns/1ps

module decode_tb import isa_pkg::*, ctl_pkg::*;;

	// Single words take about 6 cycles, stream words up to 4 with stalls
	localparam int STIM_CYCLES = 45 * 6 + 40 * 2 + 30 * 4 + 20;
	localparam int TIMEOUT = 4 * STIM_CYCLES + 100;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	insn_word_t in_word;
	logic out_valid;
	logic out_ready;
	decode_rec_t out_rec;
	logic cfg_wr;
	logic cfg_addr;
	logic [7:0] cfg_wdata;
	logic [7:0] cfg_rdata;
	r0_flags_t r0_in;
	logic q_in;
	logic p_in;
	logic invalidate;

	int cyc = 0;
	int ill_count = 0;		// Model of the illegal counter
	logic cfg_ioill = 1'b0;
	logic cfg_drop = 1'b0;

	tb_clock u_tb_clock (.clk(clk), .rst_n(rst_n));

	decode_unit u_decode_unit (
		.strob1(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_word(in_word),
		.out_valid(out_valid), .out_ready(out_ready), .out_rec(out_rec),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.r0(r0_in), .q(q_in), .p(p_in), .invalidate(invalidate)
	);

	task automatic die(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > TIMEOUT) begin
			die("Timeout, the DUT stopped responding");
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			die($sformatf("CHECK FAILED %s got=%h exp=%h", name, got, exp));
		end
	endtask

	// Decode rules, written out from the ISA description
	function automatic decode_rec_t ref_decode(input logic [15:0] w, input r0_flags_t f,
			input logic uq, input logic skip, input logic io_ill);
		decode_rec_t r;
		logic [5:0] op;
		logic [2:0] a;
		logic signed [6:0] mag;
		logic cond_clear;
		op = w[15:10];
		a = w[8:6];
		mag = {1'b0, w[5:0]};
		cond_clear = 1'b0;
		r = '0;
		r.word = w;
		if (op >= 6'o20 && op <= 6'o57) r.cls = CL_NORM;
		else if (op >= 6'o60 && op <= 6'o67) r.cls = CL_SHORT;
		else if (op == 6'o70) r.cls = CL_JUMP_S;
		else if (op == 6'o74) r.cls = CL_JUMP;
		else if (op == 6'o73) r.cls = CL_SYS;
		else if (op == 6'o77) r.cls = CL_BN;
		else if (op == 6'o06 || op == 6'o07) r.cls = CL_IO;
		else r.cls = CL_OTHER;
		r.reg_a = a;
		r.reg_b = w[5:3];
		if (r.cls == CL_SHORT) r.short_arg = w[9] ? -mag : mag;
		r.need_arg = (r.cls == CL_NORM || r.cls == CL_IO) && w[2:0] == 3'd0;
		r.illegal = (w[15:14] == 2'b00 && r.cls != CL_IO)
			|| (r.cls == CL_SYS && (a > 3'd4 || uq))
			|| (r.cls == CL_IO && uq && io_ill);
		if (r.cls == CL_JUMP_S) begin
			case (a)
				3'd4: cond_clear = !f.v;
				3'd5: cond_clear = !f.x;
				3'd6: cond_clear = !f.y;
				3'd7: cond_clear = !f.c;
				default: cond_clear = 1'b0;
			endcase
		end else if (r.cls == CL_JUMP) begin
			case (a)
				3'd1: cond_clear = !f.l;
				3'd2: cond_clear = !f.e;
				3'd3: cond_clear = !f.g;
				3'd4: cond_clear = !f.z;
				3'd5: cond_clear = !f.m;
				default: cond_clear = 1'b0;
			endcase
		end
		r.ineffective = r.illegal || skip || cond_clear;
		return r;
	endfunction

	function automatic logic [15:0] norm_word(input logic [5:0] op, input logic d,
			input logic [2:0] a, input logic [2:0] b, input logic [2:0] c);
		return {op, d, a, b, c};
	endfunction

	task automatic check_rec(input decode_rec_t got, input decode_rec_t exp);
		check_val("out_rec.word", 32'(got.word), 32'(exp.word));
		check_val("out_rec.cls", 32'(got.cls), 32'(exp.cls));
		check_val("out_rec.reg_a", 32'(got.reg_a), 32'(exp.reg_a));
		check_val("out_rec.reg_b", 32'(got.reg_b), 32'(exp.reg_b));
		check_val("out_rec.short_arg", 32'(got.short_arg), 32'(exp.short_arg));
		check_val("out_rec.need_arg", 32'(got.need_arg), 32'(exp.need_arg));
		check_val("out_rec.illegal", 32'(got.illegal), 32'(exp.illegal));
		check_val("out_rec.ineffective", 32'(got.ineffective), 32'(exp.ineffective));
	endtask

	// Returns the cycle of the accepting edge; inv pulses invalidate after it
	task automatic send_word(input logic [15:0] w, input logic inv, output int acc_cyc);
		in_valid = 1'b1;
		in_word = w;
		do @(negedge clk); while (!in_ready);
		acc_cyc = cyc + 1;
		@(posedge clk);
		#1 in_valid = 1'b0;
		if (inv) begin
			invalidate = 1'b1;	// Word now sits in the IR
			@(posedge clk);
			#1 invalidate = 1'b0;
		end
	endtask

	task automatic get_record(output decode_rec_t rec, output int hs_cyc);
		do @(negedge clk); while (!(out_valid && out_ready));
		rec = out_rec;
		hs_cyc = cyc + 1;
		@(posedge clk);
		#1;
	endtask

	task automatic run_single(input logic [15:0] w, input logic inv);
		decode_rec_t got;
		decode_rec_t exp;
		int acc;
		int hs;
		send_word(w, inv, acc);
		get_record(got, hs);
		exp = ref_decode(inv ? (w & 16'h3fff) : w, r0_in, q_in, p_in, cfg_ioill);
		check_rec(got, exp);
		if (!inv) check_val("record latency", 32'(hs - acc), 32'd2);
		if (exp.illegal) ill_count++;
	endtask

	task automatic write_cfg(input logic addr, input logic [7:0] data);
		cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
		@(posedge clk);
		#1 cfg_wr = 1'b0;
		if (addr == 1'b0) {cfg_ioill, cfg_drop} = data[1:0];
		else ill_count = 0;
	endtask

	task automatic read_check(input logic addr, input logic [7:0] exp);
		cfg_addr = addr;
		@(negedge clk);
		check_val(addr ? "cfg_rdata (illegal count)" : "cfg_rdata (ctrl)",
			32'(cfg_rdata), 32'(exp));
		@(posedge clk);
		#1;
	endtask

	// Random stream with side inputs held; stall adds out_ready gaps
	task automatic stream_run(input int n, input logic stall);
		logic [15:0] stim[$];
		decode_rec_t exp_q[$];
		decode_rec_t exp;
		decode_rec_t held_rec;
		logic held;
		int got_n;
		int n_exp;
		for (int i = 0; i < n; i++) begin
			stim.push_back(16'($urandom));
			exp = ref_decode(stim[i], r0_in, q_in, p_in, cfg_ioill);
			if (!(cfg_drop && exp.ineffective)) begin
				exp_q.push_back(exp);
				if (exp.illegal) ill_count++;
			end
		end
		n_exp = exp_q.size();
		held = 1'b0;
		got_n = 0;
		fork
			begin
				foreach (stim[i]) begin
					in_valid = 1'b1;
					in_word = stim[i];
					do @(negedge clk); while (!in_ready);
					@(posedge clk);
					#1;
				end
				in_valid = 1'b0;
			end
			begin
				while (got_n < n_exp) begin
					out_ready = stall ? ($urandom % 3 != 0) : 1'b1;
					@(negedge clk);
					if (held) begin
						assert (out_valid && out_rec == held_rec) else begin
							die("Held record changed or vanished while out_ready was low");
						end
					end
					if (out_valid && out_ready) begin
						check_rec(out_rec, exp_q.pop_front());
						got_n++;
						held = 1'b0;
					end else if (out_valid) begin
						held = 1'b1;
						held_rec = out_rec;
					end
					@(posedge clk);
					#1;
				end
				out_ready = 1'b1;
			end
		join
		repeat (4) begin
			@(negedge clk);
			assert (!out_valid) else die("DUT produced more records than expected");
		end
		@(posedge clk);
		#1;
	endtask

	task automatic test_reset_state();
		@(negedge clk);
		check_val("in_ready", 32'(in_ready), 32'd1);
		check_val("out_valid", 32'(out_valid), 32'd0);
		@(posedge clk);
		#1;
		read_check(1'b0, 8'h00);
		read_check(1'b1, 8'h00);
	endtask

	task automatic test_class_decode();
		r0_in = '0;
		q_in = 1'b0;
		p_in = 1'b0;
		run_single(norm_word(6'o20, 1'b0, 3'd1, 3'd2, 3'd0), 1'b0);	// need_arg
		run_single(norm_word(6'o45, 1'b1, 3'd7, 3'd5, 3'd3), 1'b0);
		run_single({6'o61, 1'b1, 3'd2, 6'd37}, 1'b0);	// Negative short arg
		run_single({6'o67, 1'b0, 3'd4, 6'd63}, 1'b0);
		run_single(norm_word(6'o70, 1'b0, 3'd1, 3'd0, 3'd2), 1'b0);
		run_single(norm_word(6'o74, 1'b0, 3'd0, 3'd3, 3'd1), 1'b0);
		run_single(norm_word(6'o73, 1'b0, 3'd2, 3'd0, 3'd0), 1'b0);
		run_single(norm_word(6'o77, 1'b1, 3'd3, 3'd1, 3'd6), 1'b0);
		run_single(norm_word(6'o06, 1'b0, 3'd5, 3'd2, 3'd0), 1'b0);
		run_single(norm_word(6'o07, 1'b0, 3'd1, 3'd1, 3'd4), 1'b0);
		run_single(norm_word(6'o71, 1'b0, 3'd6, 3'd7, 3'd7), 1'b0);
	endtask

	task automatic test_illegal();
		write_cfg(1'b1, 8'h00);	// Clear counter
		run_single(norm_word(6'o05, 1'b0, 3'd1, 3'd1, 3'd1), 1'b0);
		run_single(norm_word(6'o12, 1'b1, 3'd2, 3'd0, 3'd0), 1'b0);
		run_single(norm_word(6'o73, 1'b0, 3'd6, 3'd0, 3'd0), 1'b0);
		q_in = 1'b1;
		run_single(norm_word(6'o73, 1'b0, 3'd2, 3'd0, 3'd0), 1'b0);
		run_single(norm_word(6'o06, 1'b0, 3'd1, 3'd0, 3'd1), 1'b0);	// Allowed, ioill 0
		write_cfg(1'b0, 8'h02);
		run_single(norm_word(6'o06, 1'b0, 3'd1, 3'd0, 3'd1), 1'b0);
		run_single(norm_word(6'o07, 1'b0, 3'd3, 3'd2, 3'd0), 1'b0);
		q_in = 1'b0;
		run_single(norm_word(6'o06, 1'b0, 3'd1, 3'd0, 3'd1), 1'b0);
		read_check(1'b0, 8'h02);
		read_check(1'b1, 8'(ill_count));
		write_cfg(1'b0, 8'h00);
	endtask

	task automatic test_ineffective_jumps();
		int js_bit[4] = '{6, 0, 1, 5};		// v, x, y, c
		int j_bit[5] = '{4, 3, 2, 8, 7};	// l, e, g, z, m
		for (int i = 0; i < 4; i++) begin
			r0_in = r0_flags_t'(9'd1 << js_bit[i]);
			run_single(norm_word(6'o70, 1'b0, 3'(i + 4), 3'd0, 3'd1), 1'b0);
			r0_in = r0_flags_t'(~(9'd1 << js_bit[i]));
			run_single(norm_word(6'o70, 1'b0, 3'(i + 4), 3'd0, 3'd1), 1'b0);
		end
		for (int i = 0; i < 5; i++) begin
			r0_in = r0_flags_t'(9'd1 << j_bit[i]);
			run_single(norm_word(6'o74, 1'b0, 3'(i + 1), 3'd0, 3'd2), 1'b0);
			r0_in = r0_flags_t'(~(9'd1 << j_bit[i]));
			run_single(norm_word(6'o74, 1'b0, 3'(i + 1), 3'd0, 3'd2), 1'b0);
		end
		r0_in = '1;
		p_in = 1'b1;	// Skip flag hits any word
		run_single(norm_word(6'o33, 1'b0, 3'd2, 3'd1, 3'd5), 1'b0);
		run_single(norm_word(6'o77, 1'b0, 3'd0, 3'd0, 3'd0), 1'b0);
		run_single(norm_word(6'o74, 1'b0, 3'd4, 3'd0, 3'd0), 1'b0);
		p_in = 1'b0;
	endtask

	task automatic test_drop_mode();
		write_cfg(1'b0, 8'h01);
		r0_in = r0_flags_t'(9'($urandom));
		stream_run(40, 1'b0);
		write_cfg(1'b0, 8'h00);
	endtask

	task automatic test_back_pressure();
		r0_in = r0_flags_t'(9'($urandom));
		stream_run(30, 1'b1);
		read_check(1'b1, 8'(ill_count));
	endtask

	task automatic test_invalidate();
		r0_in = '0;
		run_single(norm_word(6'o73, 1'b0, 3'd2, 3'd1, 3'd3), 1'b1);	// Legal S word
		read_check(1'b1, 8'(ill_count));
	endtask

	initial begin
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b1;
		cfg_wr = 1'b0;
		cfg_addr = 1'b0;
		cfg_wdata = '0;
		r0_in = '0;
		q_in = 1'b0;
		p_in = 1'b0;
		invalidate = 1'b0;
		void'($urandom(32'h75799ccc));
		wait (rst_n);
		@(posedge clk);
		#1;
		test_reset_state();
		test_class_decode();
		test_illegal();
		test_ineffective_jumps();
		test_drop_mode();
		test_back_pressure();
		test_invalidate();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: tb.f
logic/isa_pkg.sv
logic/ctl_pkg.sv
logic/ir_stage.sv
logic/opcode_decoder.sv
logic/legality_check.sv
logic/decode_cfg.sv
logic/decode_unit.sv
verification/tb_clock.sv
verification/decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module decode_tb -f tb.f -o decode_sim
./obj_dir/decode_sim
